// ==== src.f ====
src/video_pkg.sv
src/sample_pkg.sv
src/video_timing.sv
src/sample_capture.sv
src/fb_arbiter.sv
src/scope_display.sv
testbench/sram_model.sv
testbench/tb_scope_display.sv

// ==== Bender.yml ====
package:
  name: scope_display

sources:
  - src/video_pkg.sv
  - src/sample_pkg.sv
  - src/video_timing.sv
  - src/sample_capture.sv
  - src/fb_arbiter.sv
  - src/scope_display.sv
  - target: test
    files:
      - testbench/sram_model.sv
      - testbench/tb_scope_display.sv

// ==== testbench/tb_scope_display.sv ====
// testbench for scope_display at 16x8 pixels; each stimulus row gets 30 clocks to reach the sram
module tb_scope_display;

  localparam int line_clocks     = 24;
  localparam int frame_clocks    = 288;
  localparam int row_count       = 20;
  localparam int hand_rows       = 12;
  localparam int watchdog_clocks = 2 * row_count * 32 + 2 * frame_clocks;
  // sync windows start right after the front porch
  localparam int hsync_first = 18;
  localparam int hsync_last  = 20;
  localparam int vsync_first = 9;
  localparam int vsync_last  = 10;
  // dropped strobes aim white at the last pixel, which no accepted row touches
  localparam sample_pkg::adc_word_t drop_x = 10'h3ff;
  localparam sample_pkg::adc_word_t drop_y = 10'h3ff;
  // pixel (5,5) is reserved for the two hand-written overwrite rows
  localparam int overwrite_index = 85;
  localparam video_pkg::video_t idle_video = {1'b1, 1'b1, 12'h000};

  typedef struct packed {
    sample_pkg::adc_word_t adc_x;
    sample_pkg::adc_word_t adc_y;
    logic                  red;
    logic                  grn;
    logic                  blu;
    logic                  back_to_back;
  } stim_row_t;

  logic                  pixel_clk;
  logic                  rst_n;
  sample_pkg::adc_word_t adc_x;
  sample_pkg::adc_word_t adc_y;
  logic                  adc_red;
  logic                  adc_grn;
  logic                  adc_blu;
  logic                  adc_strobe;
  video_pkg::video_t     video;
  logic [15:0]           drop_count;
  sample_pkg::fb_addr_t  sram_addr;
  logic                  sram_we_n;
  logic                  sram_oe_n;
  wire  [15:0]           sram_data;

  stim_row_t       rows [row_count];
  video_pkg::rgb_t expected_fb [128];
  video_pkg::rgb_t captured [8][16];
  int              error_count;
  int              expected_drops;

  scope_display #(
    .x_width(4),
    .y_width(3),
    .h_front(2),
    .h_sync (3),
    .h_back (3),
    .v_front(1),
    .v_sync (2),
    .v_back (1)
  ) u_scope_display (
    .pixel_clk(pixel_clk), .rst_n(rst_n),
    .adc_x(adc_x), .adc_y(adc_y), .adc_red(adc_red), .adc_grn(adc_grn),
    .adc_blu(adc_blu), .adc_strobe(adc_strobe),
    .video(video), .drop_count(drop_count),
    .sram_addr(sram_addr), .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n),
    .sram_data(sram_data)
  );

  sram_model u_sram_model (
    .addr(sram_addr), .we_n(sram_we_n), .oe_n(sram_oe_n), .data(sram_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] v;
    v = state;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic stim_row_t make_row(input logic [9:0] x, input logic [9:0] y,
                                         input logic [2:0] rgb, input logic pair);
    return stim_row_t'({x, y, rgb, pair});
  endfunction

  // top bits of each coordinate with the row above the column
  function automatic int pixel_index(input stim_row_t row);
    return {row.adc_y[9:7], row.adc_x[9:6]};
  endfunction

  function automatic video_pkg::rgb_t expand_color(input stim_row_t row);
    return {{4{row.red}}, {4{row.grn}}, {4{row.blu}}};
  endfunction

  task automatic build_table();
    logic [31:0] seed;
    seed = 32'h9a33_4759;
    rows[0]  = make_row(10'h000, 10'h000, 3'b100, 1'b0);
    rows[1]  = make_row(10'h3c0, 10'h000, 3'b010, 1'b0);
    rows[2]  = make_row(10'h000, 10'h380, 3'b001, 1'b0);
    rows[3]  = make_row(10'h2a5, 10'h1ff, 3'b110, 1'b1);
    rows[4]  = make_row(10'h07f, 10'h0ff, 3'b111, 1'b0);
    // rows 5 and 7 share pixel (5,5) and the red one must win
    rows[5]  = make_row(10'h155, 10'h2aa, 3'b011, 1'b0);
    rows[6]  = make_row(10'h3ff, 10'h37f, 3'b101, 1'b1);
    rows[7]  = make_row(10'h17f, 10'h2c0, 3'b100, 1'b0);
    rows[8]  = make_row(10'h200, 10'h100, 3'b010, 1'b1);
    rows[9]  = make_row(10'h0c0, 10'h300, 3'b001, 1'b0);
    rows[10] = make_row(10'h340, 10'h080, 3'b110, 1'b0);
    rows[11] = make_row(10'h1c0, 10'h200, 3'b101, 1'b1);
    for (int i = hand_rows; i < row_count; i++) begin
      seed = xorshift32(seed);
      rows[i] = make_row(seed[9:0], seed[19:10], seed[22:20], seed[23]);
      // keep random rows off the drop target and the overwrite pixel
      if (pixel_index(rows[i]) == 127 || pixel_index(rows[i]) == overwrite_index) begin
        rows[i].adc_x[9] = ~rows[i].adc_x[9];
      end
    end
  endtask

  task automatic check_reset_state();
    if (video !== idle_video) begin
      $display("FAIL t=%0t video expected %h got %h", $time, idle_video, video);
      error_count++;
    end
    if (drop_count !== 16'h0000) begin
      $display("FAIL t=%0t drop_count expected 0000 got %h", $time, drop_count);
      error_count++;
    end
  endtask

  task automatic apply_row(input stim_row_t row);
    @(posedge pixel_clk);
    #1;
    adc_x = row.adc_x;
    adc_y = row.adc_y;
    {adc_red, adc_grn, adc_blu} = {row.red, row.grn, row.blu};
    adc_strobe = 1'b1;
    @(posedge pixel_clk);
    #1;
    // second strobe arrives while the first handshake is still open
    if (row.back_to_back) begin
      adc_x = drop_x;
      adc_y = drop_y;
      {adc_red, adc_grn, adc_blu} = 3'b111;
      @(posedge pixel_clk);
      #1;
    end
    adc_strobe = 1'b0;
    repeat (30) @(posedge pixel_clk);
    #1;
  endtask

  task automatic capture_frame();
    logic last_vsync;
    logic exp_hsync;
    logic exp_vsync;
    int   h;
    int   v;
    @(negedge pixel_clk);
    last_vsync = video.vsync;
    @(negedge pixel_clk);
    while (!(last_vsync && !video.vsync)) begin
      last_vsync = video.vsync;
      @(negedge pixel_clk);
    end
    // now at column 0 of line 9 which is three lines before the frame wraps
    repeat (3 * line_clocks) @(negedge pixel_clk);
    for (int i = 0; i < frame_clocks; i++) begin
      h = i % line_clocks;
      v = i / line_clocks;
      exp_hsync = !(h >= hsync_first && h <= hsync_last);
      exp_vsync = !(v >= vsync_first && v <= vsync_last);
      if (video.hsync !== exp_hsync) begin
        $display("FAIL t=%0t video.hsync expected %b got %b", $time, exp_hsync, video.hsync);
        error_count++;
      end
      if (video.vsync !== exp_vsync) begin
        $display("FAIL t=%0t video.vsync expected %b got %b", $time, exp_vsync, video.vsync);
        error_count++;
      end
      if (h < 16 && v < 8) begin
        captured[v][h] = video.pixel;
      end else if (video.pixel !== '0) begin
        $display("FAIL t=%0t video.pixel expected 000 got %h", $time, video.pixel);
        error_count++;
      end
      if (i < frame_clocks - 1) @(negedge pixel_clk);
    end
  endtask

  initial begin
    pixel_clk = 1'b0;
    forever #5 pixel_clk = ~pixel_clk;
  end

  initial begin
    #(watchdog_clocks * 10);
    $display("timeout: run did not finish within %0d clocks", watchdog_clocks);
    $display("ERRORS FOUND");
    $finish;
  end

  // scan-out reads own the sram and a plot write never overlaps one
  always @(negedge pixel_clk) begin
    if (rst_n && sram_we_n === 1'b0 && sram_oe_n === 1'b0) begin
      $display("FAIL t=%0t sram_we_n expected 1 got 0 while sram_oe_n is low", $time);
      error_count++;
    end
  end

  initial begin
    rst_n = 1'b0;
    adc_x = '0;
    adc_y = '0;
    {adc_red, adc_grn, adc_blu, adc_strobe} = 4'b0000;
    error_count = 0;
    expected_drops = 0;
    for (int i = 0; i < 128; i++) expected_fb[i] = '0;
    build_table();
    repeat (8) begin
      @(posedge pixel_clk);
      #1;
      check_reset_state();
      if (sram_we_n !== 1'b1 || sram_oe_n !== 1'b1) begin
        $display("FAIL t=%0t sram_we_n/sram_oe_n expected 1/1 got %b/%b", $time,
                 sram_we_n, sram_oe_n);
        error_count++;
      end
    end
    rst_n = 1'b1;
    @(posedge pixel_clk);
    #1;
    check_reset_state();
    for (int r = 0; r < row_count; r++) begin
      apply_row(rows[r]);
      expected_fb[pixel_index(rows[r])] = expand_color(rows[r]);
      if (rows[r].back_to_back) expected_drops++;
      if (drop_count !== 16'(expected_drops)) begin
        $display("FAIL t=%0t drop_count expected %0d got %0d", $time, expected_drops, drop_count);
        error_count++;
      end
    end
    capture_frame();
    for (int v = 0; v < 8; v++) begin
      for (int h = 0; h < 16; h++) begin
        if (captured[v][h] !== expected_fb[v * 16 + h]) begin
          $display("FAIL t=%0t video.pixel(%0d,%0d) expected %h got %h", $time, h, v,
                   expected_fb[v * 16 + h], captured[v][h]);
          error_count++;
        end
      end
    end
    // later of the two plots at (5,5) is full red
    if (captured[5][5] !== 12'hf00) begin
      $display("FAIL t=%0t video.pixel(5,5) expected f00 got %h", $time, captured[5][5]);
      error_count++;
    end
    $display("run complete with %0d errors", error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== testbench/sram_model.sv ====
// async sram with zeroed contents; a write lands 2 time units into the we_n pulse and reads have no delay
module sram_model #(
  parameter int addr_width = 19
) (
  input  logic [addr_width-1:0] addr,
  input  logic                  we_n,
  input  logic                  oe_n,
  inout  wire  [15:0]           data
);

  logic [15:0] mem [0:(1 << addr_width)-1];

  initial begin
    for (int i = 0; i < (1 << addr_width); i++) begin
      mem[i] = '0;
    end
  end

  // address and data have settled by the time the write is taken
  always @(negedge we_n) begin
    #2;
    if (we_n === 1'b0) begin
      mem[addr] = data;
    end
  end

  // bus only driven for a read with no write pending
  assign data = (!oe_n && we_n) ? mem[addr] : 16'hzzzz;

endmodule

// ==== src/scope_display.sv ====
// x/y display top; everything on pixel_clk, sram byte lanes are left to the board
module scope_display #(
  parameter int x_width = 9,
  parameter int y_width = 8,
  parameter int h_front = 16,
  parameter int h_sync  = 96,
  parameter int h_back  = 48,
  parameter int v_front = 10,
  parameter int v_sync  = 2,
  parameter int v_back  = 33
) (
  input  logic                   pixel_clk,
  input  logic                   rst_n,

  // adc side, strobe marks a valid sample
  input  sample_pkg::adc_word_t  adc_x,
  input  sample_pkg::adc_word_t  adc_y,
  input  logic                   adc_red,
  input  logic                   adc_grn,
  input  logic                   adc_blu,
  input  logic                   adc_strobe,

  output video_pkg::video_t      video,
  output logic [15:0]            drop_count,

  // external async sram
  output sample_pkg::fb_addr_t   sram_addr,
  output logic                   sram_we_n,
  output logic                   sram_oe_n,
  inout  wire [15:0]             sram_data
);

  video_pkg::coord_t      scan_x;
  video_pkg::coord_t      scan_y;
  logic                   scan_active;
  logic                   scan_hsync;
  logic                   scan_vsync;
  sample_pkg::plot_req_t  plot;
  logic                   plot_req;
  logic                   plot_ack;

  video_timing #(
    .x_width(x_width),
    .y_width(y_width),
    .h_front(h_front),
    .h_sync (h_sync),
    .h_back (h_back),
    .v_front(v_front),
    .v_sync (v_sync),
    .v_back (v_back)
  ) u_video_timing (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .scan_x     (scan_x),
    .scan_y     (scan_y),
    .scan_active(scan_active),
    .scan_hsync (scan_hsync),
    .scan_vsync (scan_vsync)
  );

  sample_capture #(
    .x_width(x_width),
    .y_width(y_width)
  ) u_sample_capture (
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_red   (adc_red),
    .adc_grn   (adc_grn),
    .adc_blu   (adc_blu),
    .adc_strobe(adc_strobe),
    .plot_ack  (plot_ack),
    .plot      (plot),
    .plot_req  (plot_req),
    .drop_count(drop_count)
  );

  fb_arbiter #(
    .x_width(x_width),
    .y_width(y_width)
  ) u_fb_arbiter (
    .pixel_clk  (pixel_clk),
    .rst_n      (rst_n),
    .scan_x     (scan_x),
    .scan_y     (scan_y),
    .scan_active(scan_active),
    .scan_hsync (scan_hsync),
    .scan_vsync (scan_vsync),
    .plot       (plot),
    .plot_req   (plot_req),
    .plot_ack   (plot_ack),
    .sram_addr  (sram_addr),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .video      (video),
    .sram_data  (sram_data)
  );

endmodule

// ==== src/fb_arbiter.sv ====
// sram port sharing; scan-out reads always win, plot writes only land in blanking cycles
module fb_arbiter #(
  parameter int x_width = 9,
  parameter int y_width = 8
) (
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  input  video_pkg::coord_t      scan_x,
  input  video_pkg::coord_t      scan_y,
  input  logic                   scan_active,
  input  logic                   scan_hsync,
  input  logic                   scan_vsync,
  input  sample_pkg::plot_req_t  plot,
  input  logic                   plot_req,
  output logic                   plot_ack,
  output sample_pkg::fb_addr_t   sram_addr,
  output logic                   sram_we_n,
  output logic                   sram_oe_n,
  output video_pkg::video_t      video,
  inout  wire [15:0]             sram_data
);

  typedef enum logic [1:0] {
    arb_wait,
    arb_ack,
    arb_drop_ack
  } arb_state_t;

  arb_state_t              state;
  logic                    write_cycle;
  sample_pkg::fb_addr_t    read_addr;
  video_pkg::rgb_t         read_pixel;

  // framebuffer address is simply y above x
  assign read_addr = sample_pkg::fb_addr_t'({scan_y[y_width-1:0], scan_x[x_width-1:0]});

  // one-cycle write, only while the scan is blanked
  assign write_cycle = !scan_active && plot_req && (state == arb_wait);

  assign sram_addr = scan_active ? read_addr : plot.addr;
  assign sram_oe_n = !scan_active;
  assign sram_we_n = !write_cycle;
  assign sram_data = write_cycle ? plot.word : 16'hzzzz;

  assign read_pixel = video_pkg::rgb_t'(sram_data[$bits(video_pkg::rgb_t)-1:0]);

  // four-phase handshake, ack rises the clock after the write
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state <= arb_wait;
    end else begin
      case (state)
        arb_wait:     if (write_cycle) state <= arb_ack;
        arb_ack:      if (!plot_req) state <= arb_drop_ack;
        arb_drop_ack: state <= arb_wait;
        default:      state <= arb_wait;
      endcase
    end
  end

  assign plot_ack = (state == arb_ack);

  // read data and syncs share one register stage
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      video.hsync <= 1'b1;
      video.vsync <= 1'b1;
      video.pixel <= '0;
    end else begin
      video.hsync <= scan_hsync;
      video.vsync <= scan_vsync;
      // black outside the visible area
      if (scan_active) begin
        video.pixel <= read_pixel;
      end else begin
        video.pixel <= '0;
      end
    end
  end

endmodule

// ==== src/sample_capture.sv ====
// single-clock sampler; one plot in flight at a time, strobes during a handshake are dropped
module sample_capture #(
  parameter int x_width = 9,
  parameter int y_width = 8
) (
  input  logic                   pixel_clk,
  input  logic                   rst_n,
  input  sample_pkg::adc_word_t  adc_x,
  input  sample_pkg::adc_word_t  adc_y,
  input  logic                   adc_red,
  input  logic                   adc_grn,
  input  logic                   adc_blu,
  input  logic                   adc_strobe,
  input  logic                   plot_ack,
  output sample_pkg::plot_req_t  plot,
  output logic                   plot_req,
  output logic [15:0]            drop_count
);

  localparam int adc_width = $bits(sample_pkg::adc_word_t);
  localparam int pad_width = $bits(sample_pkg::fb_word_t) - $bits(video_pkg::rgb_t);

  typedef enum logic [1:0] {
    cap_idle,
    cap_request,
    cap_release
  } cap_state_t;

  cap_state_t           state;
  logic                 accept;
  logic                 drop;
  video_pkg::rgb_t      color;
  logic [x_width-1:0]   pos_x;
  logic [y_width-1:0]   pos_y;

  // new request only once both req and ack are low
  assign accept = adc_strobe && (state != cap_request) && !plot_ack;
  assign drop   = adc_strobe && !accept;

  // scale by keeping the top bits of each coordinate
  assign pos_x = adc_x[adc_width-1 -: x_width];
  assign pos_y = adc_y[adc_width-1 -: y_width];

  // one color bit per channel, full or off
  assign color.red = {video_pkg::color_width{adc_red}};
  assign color.grn = {video_pkg::color_width{adc_grn}};
  assign color.blu = {video_pkg::color_width{adc_blu}};

  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      state <= cap_idle;
    end else if (accept) begin
      state <= cap_request;
    end else begin
      case (state)
        cap_request: if (plot_ack) state <= cap_release;
        cap_release: if (!plot_ack) state <= cap_idle;
        default:     state <= cap_idle;
      endcase
    end
  end

  assign plot_req = (state == cap_request);

  // payload held until the next accepted strobe
  always_ff @(posedge pixel_clk) begin
    if (accept) begin
      plot.addr <= sample_pkg::fb_addr_t'({pos_y, pos_x});
      plot.word <= {{pad_width{1'b0}}, color};
    end
  end

  // saturating count of lost strobes
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (drop && (drop_count != 16'hffff)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

// ==== src/video_timing.sv ====
// scan timing for a 2**x_width by 2**y_width visible area; counters start at the first active pixel
module video_timing #(
  parameter int x_width = 9,
  parameter int y_width = 8,
  parameter int h_front = 16,
  parameter int h_sync  = 96,
  parameter int h_back  = 48,
  parameter int v_front = 10,
  parameter int v_sync  = 2,
  parameter int v_back  = 33
) (
  input  logic                pixel_clk,
  input  logic                rst_n,
  output video_pkg::coord_t   scan_x,
  output video_pkg::coord_t   scan_y,
  output logic                scan_active,
  output logic                scan_hsync,
  output logic                scan_vsync
);

  localparam int h_active = 1 << x_width;
  localparam int v_active = 1 << y_width;
  localparam int h_total  = h_active + h_front + h_sync + h_back;
  localparam int v_total  = v_active + v_front + v_sync + v_back;

  // sync windows sit right after the front porch
  localparam video_pkg::coord_t h_sync_start = video_pkg::coord_t'(h_active + h_front);
  localparam video_pkg::coord_t h_sync_end   = video_pkg::coord_t'(h_active + h_front + h_sync);
  localparam video_pkg::coord_t v_sync_start = video_pkg::coord_t'(v_active + v_front);
  localparam video_pkg::coord_t v_sync_end   = video_pkg::coord_t'(v_active + v_front + v_sync);
  localparam video_pkg::coord_t h_last       = video_pkg::coord_t'(h_total - 1);
  localparam video_pkg::coord_t v_last       = video_pkg::coord_t'(v_total - 1);
  localparam video_pkg::coord_t h_end_active = video_pkg::coord_t'(h_active);
  localparam video_pkg::coord_t v_end_active = video_pkg::coord_t'(v_active);

  video_pkg::coord_t h_cnt;
  video_pkg::coord_t v_cnt;

  // horizontal counter wraps each line and steps the line counter
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == h_last) begin
      h_cnt <= '0;
      if (v_cnt == v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // decoded from the current count, so outputs trail the counters by one clock
  always_ff @(posedge pixel_clk) begin
    if (!rst_n) begin
      scan_x      <= '0;
      scan_y      <= '0;
      scan_active <= 1'b0;
      scan_hsync  <= 1'b1;
      scan_vsync  <= 1'b1;
    end else begin
      scan_x      <= h_cnt;
      scan_y      <= v_cnt;
      scan_active <= (h_cnt < h_end_active) && (v_cnt < v_end_active);
      scan_hsync  <= !((h_cnt >= h_sync_start) && (h_cnt < h_sync_end));
      // vsync covers whole lines
      scan_vsync  <= !((v_cnt >= v_sync_start) && (v_cnt < v_sync_end));
    end
  end

endmodule

// ==== src/sample_pkg.sv ====
// sample and framebuffer types; the sram word carries an rgb_t in its low 12 bits, top bits zero
package sample_pkg;

  // one adc coordinate, full converter resolution
  typedef logic [9:0] adc_word_t;

  // word address into the external sram
  typedef logic [18:0] fb_addr_t;

  // one sram data word
  typedef logic [15:0] fb_word_t;

  // plot request handed from the sampler to the arbiter
  // must stay stable while plot_req is high
  typedef struct packed {
    fb_addr_t addr;
    fb_word_t word;
  } plot_req_t;

endpackage

// ==== src/video_pkg.sv ====
// video types; coord_t is 12 bits wide and modules use only the low x_width or y_width bits
package video_pkg;

  // per-channel color depth on the vga output
  localparam int color_width = 4;

  // horizontal and vertical counter values and pixel coordinates
  typedef logic [11:0] coord_t;

  // one pixel as it leaves the display
  typedef struct packed {
    logic [color_width-1:0] red;
    logic [color_width-1:0] grn;
    logic [color_width-1:0] blu;
  } rgb_t;

  // complete video output bundle
  // sync lines are active low
  typedef struct packed {
    logic hsync;
    logic vsync;
    rgb_t pixel;
  } video_t;

endpackage
